// ==== rtl/proc_ctrl_pkg.sv ====
package proc_ctrl_pkg;

	// instruction word III XXX YYY
	localparam int INSTR_W   = 9;
	localparam int REG_SEL_W = 3;
	localparam int OPCODE_W  = 3;

	// bit positions of the fields inside the word
	localparam int OP_LSB = 6;
	localparam int X_LSB  = 3;
	localparam int Y_LSB  = 0;

	localparam int NUM_REGS = 8;	// r0..r7

	typedef enum logic [OPCODE_W-1:0]
	{
		OP_MV   = 3'd0,
		OP_MVI  = 3'd1,
		OP_ADD  = 3'd2,
		OP_SUB  = 3'd3,
		OP_LD   = 3'd4,
		OP_ST   = 3'd5,
		OP_MVNZ = 3'd6	// code 7 left undefined
	} opcode_t;

	typedef enum logic [3:0]
	{
		S_IDLE,
		S_INC,		// pc increment, address load
		S_WAIT_IR,	// ir capture
		S_FETCH,	// decode, g flag capture
		S_MV,
		S_MVI,
		S_AS1,
		S_AS2,
		S_AS3,
		S_LD1,
		S_LD2,
		S_LD3,
		S_ST1,
		S_ST2,
		S_ST3,
		S_MVNZ
	} state_t;

endpackage

// ==== rtl/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode import proc_ctrl_pkg::*;
#(
	parameter int DATA_W = 9
)
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic [INSTR_W-1:0]   ir,
	input  logic                 ir_in,
	input  logic [DATA_W-1:0]    g_data,
	input  logic                 check_g,
	output logic [REG_SEL_W-1:0] x_field,
	output logic [REG_SEL_W-1:0] y_field,
	output logic                 is_mv,
	output logic                 is_mvi,
	output logic                 is_add,
	output logic                 is_sub,
	output logic                 is_ld,
	output logic                 is_st,
	output logic                 is_mvnz,
	output logic                 g_nonzero
);

	logic [INSTR_W-1:0] ir_stored;
	opcode_t            opcode;

	always_ff @(posedge clk)
	begin
		if (reset)
			ir_stored <= '0;
		else if (ir_in)
			ir_stored <= ir;
	end

	// flag taken from G while the fetch step is active
	always_ff @(posedge clk)
	begin
		if (reset)
			g_nonzero <= 1'b0;
		else if (check_g)
			g_nonzero <= (g_data != '0);
	end

	assign opcode  = opcode_t'(ir_stored[OP_LSB +: OPCODE_W]);
	assign x_field = ir_stored[X_LSB +: REG_SEL_W];
	assign y_field = ir_stored[Y_LSB +: REG_SEL_W];

	// one flag per opcode, all low for code 7
	always_comb
	begin
		is_mv   = (opcode == OP_MV);
		is_mvi  = (opcode == OP_MVI);
		is_add  = (opcode == OP_ADD);
		is_sub  = (opcode == OP_SUB);
		is_ld   = (opcode == OP_LD);
		is_st   = (opcode == OP_ST);
		is_mvnz = (opcode == OP_MVNZ);
	end

endmodule : instr_decode

// ==== rtl/reg_select.sv ====
`timescale 1ns/1ps

module reg_select import proc_ctrl_pkg::*;
(
	input  logic [REG_SEL_W-1:0] x_field,
	input  logic [REG_SEL_W-1:0] y_field,
	input  logic                 out_x,
	input  logic                 out_y,
	input  logic                 in_x,
	output logic [NUM_REGS-1:0]  r_out,
	output logic [NUM_REGS-1:0]  r_in
);

	logic [REG_SEL_W-1:0] src_field;
	logic [NUM_REGS-1:0]  x_onehot;
	logic [NUM_REGS-1:0]  src_onehot;

	// out_x wins, the fsm never raises both
	assign src_field = out_x ? x_field : y_field;

	always_comb
	begin
		x_onehot = '0;
		x_onehot[x_field] = 1'b1;
	end

	always_comb
	begin
		src_onehot = '0;
		src_onehot[src_field] = 1'b1;
	end

	always_comb
	begin
		r_out = '0;
		r_in  = '0;
		if (out_x || out_y)
			r_out = src_onehot;	// read select
		if (in_x)
			r_in = x_onehot;	// write select, always X
	end

endmodule : reg_select

// ==== rtl/ctrl_fsm.sv ====
`timescale 1ns/1ps

module ctrl_fsm import proc_ctrl_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic run,
	input  logic is_mv,
	input  logic is_mvi,
	input  logic is_add,
	input  logic is_sub,
	input  logic is_ld,
	input  logic is_st,
	input  logic is_mvnz,
	input  logic g_nonzero,
	output logic ir_in,
	output logic check_g,
	output logic out_x,
	output logic out_y,
	output logic in_x,
	output logic a_in,
	output logic g_in,
	output logic g_out,
	output logic addsub,
	output logic din_out,
	output logic incr_pc,
	output logic addr_in,
	output logic pc_out,
	output logic dout_in,
	output logic w_d,
	output logic done
);

	state_t state;
	state_t next_state;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= S_IDLE;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = S_IDLE;
		case (state)
			S_IDLE:
				next_state = S_INC;
			S_INC:
				next_state = S_WAIT_IR;
			S_WAIT_IR:
				next_state = S_FETCH;
			S_FETCH:
			begin
				if (!run)
					next_state = S_IDLE;	// halted, refetch
				else if (is_mv)
					next_state = S_MV;
				else if (is_mvi)
					next_state = S_MVI;
				else if (is_add || is_sub)
					next_state = S_AS1;
				else if (is_ld)
					next_state = S_LD1;
				else if (is_st)
					next_state = S_ST1;
				else if (is_mvnz)
					next_state = S_MVNZ;
				else
					next_state = S_IDLE;	// opcode 7
			end
			S_AS1:
				next_state = S_AS2;
			S_AS2:
				next_state = S_AS3;
			S_LD1:
				next_state = S_LD2;
			S_LD2:
				next_state = S_LD3;
			S_ST1:
				next_state = S_ST2;
			S_ST2:
				next_state = S_ST3;
			default:
				next_state = S_IDLE;	// single steps and last steps
		endcase
	end

	always_comb
	begin
		ir_in   = 1'b0;
		check_g = 1'b0;
		out_x   = 1'b0;
		out_y   = 1'b0;
		in_x    = 1'b0;
		a_in    = 1'b0;
		g_in    = 1'b0;
		g_out   = 1'b0;
		addsub  = 1'b0;
		din_out = 1'b0;
		incr_pc = 1'b0;
		addr_in = 1'b0;
		pc_out  = 1'b0;
		dout_in = 1'b0;
		w_d     = 1'b0;
		done    = 1'b0;
		case (state)
			S_INC:
			begin
				incr_pc = 1'b1;
				addr_in = 1'b1;
				pc_out  = 1'b1;	// pc onto the address bus
			end
			S_WAIT_IR:
				ir_in = 1'b1;
			S_FETCH:
				check_g = 1'b1;
			S_MV:
			begin
				out_y = 1'b1;
				in_x  = 1'b1;
				done  = 1'b1;
			end
			S_MVI:
			begin
				din_out = 1'b1;	// immediate from din
				in_x    = 1'b1;
				done    = 1'b1;
			end
			S_AS1:
			begin
				out_x  = 1'b1;
				a_in   = 1'b1;
				addsub = is_sub;
			end
			S_AS2:
			begin
				out_y  = 1'b1;
				g_in   = 1'b1;	// result into G
				addsub = is_sub;
			end
			S_AS3:
			begin
				g_out  = 1'b1;
				in_x   = 1'b1;
				addsub = is_sub;
				done   = 1'b1;
			end
			S_LD1:
			begin
				out_y   = 1'b1;
				addr_in = 1'b1;
			end
			S_LD3:
			begin
				din_out = 1'b1;
				in_x    = 1'b1;
				done    = 1'b1;
			end
			S_ST1:
			begin
				out_y   = 1'b1;
				addr_in = 1'b1;
			end
			S_ST2:
			begin
				out_x   = 1'b1;
				dout_in = 1'b1;
			end
			S_ST3:
			begin
				w_d  = 1'b1;
				done = 1'b1;
			end
			S_MVNZ:
			begin
				out_y = g_nonzero;	// move only on G != 0
				in_x  = g_nonzero;
				done  = 1'b1;
			end
			default:
			begin
				done = 1'b0;	// idle and ld2 drive nothing
			end
		endcase
	end

endmodule : ctrl_fsm

// ==== rtl/proc_ctrl.sv ====
`timescale 1ns/1ps

module proc_ctrl import proc_ctrl_pkg::*;
#(
	parameter int DATA_W = 9
)
(
	input  logic                clk,
	input  logic                reset,
	input  logic                run,
	input  logic [INSTR_W-1:0]  ir,
	input  logic [DATA_W-1:0]   g_data,
	output logic [NUM_REGS-1:0] r_out,
	output logic [NUM_REGS-1:0] r_in,
	output logic                a_in,
	output logic                g_in,
	output logic                g_out,
	output logic                addsub,
	output logic                din_out,
	output logic                ir_in,
	output logic                incr_pc,
	output logic                addr_in,
	output logic                pc_out,
	output logic                dout_in,
	output logic                w_d,
	output logic                done
);

	logic [REG_SEL_W-1:0] x_field;
	logic [REG_SEL_W-1:0] y_field;
	logic                 is_mv;
	logic                 is_mvi;
	logic                 is_add;
	logic                 is_sub;
	logic                 is_ld;
	logic                 is_st;
	logic                 is_mvnz;
	logic                 g_nonzero;
	logic                 check_g;
	logic                 out_x;
	logic                 out_y;
	logic                 in_x;

	instr_decode #(
		.DATA_W    (DATA_W)
	) decode_i (
		.clk       (clk),
		.reset     (reset),
		.ir        (ir),
		.ir_in     (ir_in),
		.g_data    (g_data),
		.check_g   (check_g),
		.x_field   (x_field),
		.y_field   (y_field),
		.is_mv     (is_mv),
		.is_mvi    (is_mvi),
		.is_add    (is_add),
		.is_sub    (is_sub),
		.is_ld     (is_ld),
		.is_st     (is_st),
		.is_mvnz   (is_mvnz),
		.g_nonzero (g_nonzero)
	);

	ctrl_fsm fsm_i (
		.clk       (clk),
		.reset     (reset),
		.run       (run),
		.is_mv     (is_mv),
		.is_mvi    (is_mvi),
		.is_add    (is_add),
		.is_sub    (is_sub),
		.is_ld     (is_ld),
		.is_st     (is_st),
		.is_mvnz   (is_mvnz),
		.g_nonzero (g_nonzero),
		.ir_in     (ir_in),
		.check_g   (check_g),
		.out_x     (out_x),
		.out_y     (out_y),
		.in_x      (in_x),
		.a_in      (a_in),
		.g_in      (g_in),
		.g_out     (g_out),
		.addsub    (addsub),
		.din_out   (din_out),
		.incr_pc   (incr_pc),
		.addr_in   (addr_in),
		.pc_out    (pc_out),
		.dout_in   (dout_in),
		.w_d       (w_d),
		.done      (done)
	);

	reg_select select_i (
		.x_field   (x_field),
		.y_field   (y_field),
		.out_x     (out_x),
		.out_y     (out_y),
		.in_x      (in_x),
		.r_out     (r_out),
		.r_in      (r_in)
	);

endmodule : proc_ctrl

// ==== verif/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen
#(
	parameter int PERIOD       = 10,
	parameter int RESET_CYCLES = 5
)
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD/2) clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0;	// same offset as the other inputs
	end

endmodule : clk_gen

// ==== verif/proc_ctrl_sva.sv ====
`timescale 1ns/1ps

module proc_ctrl_sva import proc_ctrl_pkg::*;
(
	input logic                clk,
	input logic                reset,
	input logic [NUM_REGS-1:0] r_out,
	input logic [NUM_REGS-1:0] r_in,
	input logic                incr_pc,
	input logic                ir_in,
	input logic                done
);

	int failures = 0;	// read by the testbench at the end

	assert property (@(posedge clk) disable iff (reset) $onehot0(r_in))
	else
	begin
		$error("r_in has more than one register selected");
		failures++;
	end

	assert property (@(posedge clk) disable iff (reset) $onehot0(r_out))
	else
	begin
		$error("r_out has more than one register selected");
		failures++;
	end

	assert property (@(posedge clk) disable iff (reset) incr_pc |=> ir_in)
	else
	begin
		$error("ir_in missing in the cycle after incr_pc");
		failures++;
	end

	assert property (@(posedge clk) disable iff (reset) done |=> !done)
	else
	begin
		$error("done high for two cycles in a row");
		failures++;
	end

endmodule : proc_ctrl_sva

bind proc_ctrl proc_ctrl_sva sva_i
(
	.clk     (clk),
	.reset   (reset),
	.r_out   (r_out),
	.r_in    (r_in),
	.incr_pc (incr_pc),
	.ir_in   (ir_in),
	.done    (done)
);

// ==== verif/proc_ctrl_tb.sv ====
`timescale 1ns/1ps

module proc_ctrl_tb import proc_ctrl_pkg::*; ();

	localparam int DATA_W       = 9;
	localparam int NUM_INSTR    = 300;
	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 5;
	localparam int MAX_CYCLES   = 8;	// longest instruction is 7 cycles with idle
	localparam int TIMEOUT_NS   = (NUM_INSTR * MAX_CYCLES + RESET_CYCLES) * CLK_PERIOD * 2;

	localparam int T_RESET   = 0;
	localparam int T_FETCH   = 1;
	localparam int T_SINGLE  = 2;
	localparam int T_ADDSUB  = 3;
	localparam int T_LDST    = 4;
	localparam int T_HALT    = 5;
	localparam int NUM_TESTS = 6;

	// one bit per control output, same order as ctrl_bus
	localparam logic [11:0] M_A_IN    = 12'h001;
	localparam logic [11:0] M_G_IN    = 12'h002;
	localparam logic [11:0] M_G_OUT   = 12'h004;
	localparam logic [11:0] M_ADDSUB  = 12'h008;
	localparam logic [11:0] M_DIN_OUT = 12'h010;
	localparam logic [11:0] M_IR_IN   = 12'h020;
	localparam logic [11:0] M_INCR_PC = 12'h040;
	localparam logic [11:0] M_ADDR_IN = 12'h080;
	localparam logic [11:0] M_PC_OUT  = 12'h100;
	localparam logic [11:0] M_DOUT_IN = 12'h200;
	localparam logic [11:0] M_W_D     = 12'h400;
	localparam logic [11:0] M_DONE    = 12'h800;

	string ctrl_names [12] = '{"a_in", "g_in", "g_out", "addsub", "din_out", "ir_in",
		"incr_pc", "addr_in", "pc_out", "dout_in", "w_d", "done"};
	string test_names [NUM_TESTS] = '{"reset", "fetch", "mv/mvi/mvnz", "add/sub",
		"ld/st", "halt/opcode 7"};

	logic                clk;
	logic                reset;
	logic                run;
	logic [INSTR_W-1:0]  ir;
	logic [DATA_W-1:0]   g_data;
	logic [NUM_REGS-1:0] r_out;
	logic [NUM_REGS-1:0] r_in;
	logic                a_in;
	logic                g_in;
	logic                g_out;
	logic                addsub;
	logic                din_out;
	logic                ir_in;
	logic                incr_pc;
	logic                addr_in;
	logic                pc_out;
	logic                dout_in;
	logic                w_d;
	logic                done;
	logic [11:0]         ctrl_bus;

	int errors [NUM_TESTS];
	int runs [NUM_TESTS];
	int checks;
	int cur_test;
	int total_errors;

	assign ctrl_bus = {done, w_d, dout_in, pc_out, addr_in, incr_pc, ir_in, din_out,
		addsub, g_out, g_in, a_in};

	clk_gen #(
		.PERIOD       (CLK_PERIOD),
		.RESET_CYCLES (RESET_CYCLES)
	) clkgen_i (
		.clk          (clk),
		.reset        (reset)
	);

	proc_ctrl #(
		.DATA_W  (DATA_W)
	) dut_i (
		.clk     (clk),
		.reset   (reset),
		.run     (run),
		.ir      (ir),
		.g_data  (g_data),
		.r_out   (r_out),
		.r_in    (r_in),
		.a_in    (a_in),
		.g_in    (g_in),
		.g_out   (g_out),
		.addsub  (addsub),
		.din_out (din_out),
		.ir_in   (ir_in),
		.incr_pc (incr_pc),
		.addr_in (addr_in),
		.pc_out  (pc_out),
		.dout_in (dout_in),
		.w_d     (w_d),
		.done    (done)
	);

	task automatic drive_inputs();
		ir = INSTR_W'($urandom);
		if ($urandom_range(1, 0) == 0)
			g_data = '0;
		else
		begin
			do
				g_data = DATA_W'($urandom);
			while (g_data == '0);
		end
		run = ($urandom_range(7, 0) != 0);	// low one time in eight
	endtask

	// drive shortly after the edge, leave the check for mid cycle
	task automatic next_cycle();
		@(posedge clk);
		#1;
		drive_inputs();
		#4;
	endtask

	task automatic check_value(input string name, input logic [NUM_REGS-1:0] exp_v,
		input logic [NUM_REGS-1:0] act_v);
		checks++;
		assert (act_v === exp_v)
		else
		begin
			$display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, exp_v, act_v);
			errors[cur_test]++;
		end
	endtask

	task automatic check_outputs(input logic [NUM_REGS-1:0] exp_out,
		input logic [NUM_REGS-1:0] exp_in, input logic [11:0] exp_ctrl);
		check_value("r_out", exp_out, r_out);
		check_value("r_in", exp_in, r_in);
		for (int i = 0; i < 12; i++)
			check_value(ctrl_names[i], NUM_REGS'(exp_ctrl[i]), NUM_REGS'(ctrl_bus[i]));
	endtask

	// one fetch and execute pass, ending with the idle cycle
	task automatic run_instruction();
		logic [INSTR_W-1:0]  word;
		logic                nz;
		logic                go;
		logic [2:0]          op;
		logic [NUM_REGS-1:0] x_sel;
		logic [NUM_REGS-1:0] y_sel;
		logic [11:0]         sub_mask;
		cur_test = T_FETCH;
		runs[T_FETCH]++;
		next_cycle();
		check_outputs('0, '0, M_INCR_PC | M_ADDR_IN | M_PC_OUT);
		next_cycle();
		word = ir;	// captured at the end of the ir_in cycle
		check_outputs('0, '0, M_IR_IN);
		next_cycle();
		nz = (g_data != '0);
		go = run;
		check_outputs('0, '0, '0);
		op = word[8:6];
		x_sel = NUM_REGS'(1) << word[5:3];
		y_sel = NUM_REGS'(1) << word[2:0];
		sub_mask = (op == OP_SUB) ? M_ADDSUB : '0;
		if (!go || op == 3'd7)
			cur_test = T_HALT;
		else if (op == OP_MV || op == OP_MVI || op == OP_MVNZ)
		begin
			cur_test = T_SINGLE;
			next_cycle();
			if (op == OP_MV)
				check_outputs(y_sel, x_sel, M_DONE);
			else if (op == OP_MVI)
				check_outputs('0, x_sel, M_DIN_OUT | M_DONE);
			else if (nz)
				check_outputs(y_sel, x_sel, M_DONE);
			else
				check_outputs('0, '0, M_DONE);
		end
		else if (op == OP_ADD || op == OP_SUB)
		begin
			cur_test = T_ADDSUB;
			next_cycle();
			check_outputs(x_sel, '0, M_A_IN | sub_mask);
			next_cycle();
			check_outputs(y_sel, '0, M_G_IN | sub_mask);
			next_cycle();
			check_outputs('0, x_sel, M_G_OUT | sub_mask | M_DONE);
		end
		else
		begin
			cur_test = T_LDST;
			next_cycle();
			check_outputs(y_sel, '0, M_ADDR_IN);
			next_cycle();
			if (op == OP_LD)
				check_outputs('0, '0, '0);
			else
				check_outputs(x_sel, '0, M_DOUT_IN);
			next_cycle();
			if (op == OP_LD)
				check_outputs('0, x_sel, M_DIN_OUT | M_DONE);
			else
				check_outputs('0, '0, M_W_D | M_DONE);
		end
		runs[cur_test]++;
		next_cycle();
		check_outputs('0, '0, '0);	// back in idle, nothing active
	endtask

	task automatic report_test(input int t);
		$display("test %-14s %4d runs, %0d errors, %s", test_names[t], runs[t], errors[t],
			(errors[t] == 0) ? "ok" : "FAIL");
	endtask

	initial
	begin
		void'($urandom(87507));
		run = 1'b0;
		ir = '0;
		g_data = '0;
		checks = 0;
		total_errors = 0;
		cur_test = T_RESET;
		foreach (errors[t])
		begin
			errors[t] = 0;
			runs[t] = 0;
		end
		do
		begin
			next_cycle();
			check_outputs('0, '0, '0);
		end
		while (reset);	// last pass is the idle cycle after reset
		runs[T_RESET] = 1;
		report_test(T_RESET);
		repeat (NUM_INSTR) run_instruction();
		for (int t = T_FETCH; t < NUM_TESTS; t++)
			report_test(t);
		assert (dut_i.sva_i.failures == 0)
		else
		begin
			$display("concurrent assertions failed %0d times", dut_i.sva_i.failures);
			total_errors++;
		end
		foreach (errors[t])
			total_errors += errors[t];
		$display("%0d checks, %0d errors", checks, total_errors);
		if (total_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns, run did not finish", TIMEOUT_NS);
		$display("sim failed");
		$finish;
	end

endmodule : proc_ctrl_tb

// ==== proc_ctrl.f ====
rtl/proc_ctrl_pkg.sv
rtl/instr_decode.sv
rtl/reg_select.sv
rtl/ctrl_fsm.sv
rtl/proc_ctrl.sv
verif/clk_gen.sv
verif/proc_ctrl_sva.sv
verif/proc_ctrl_tb.sv

// ==== Makefile ====
TOOL     = verilator
TOP      = proc_ctrl_tb
FILELIST = proc_ctrl.f
FLAGS    = --binary --timing --assert -j 0
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SOURCES  = $(filter %.sv,$(shell cat $(FILELIST)))

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

clean:
	rm -rf $(BUILD)
